//--- hw/id_pkg.sv
// Decode stage types, RV32I encodings and the NOP used for IF/ID squashes
package id_pkg;

    // ==================================================
    // Encodings
    // ==================================================
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,                // lb/lh/lw/lbu/lhu
        OP_STORE  = 7'b0100011,                // sb/sh/sw
        OP_IMM    = 7'b0010011,                // Register-immediate ALU
        OP_OP     = 7'b0110011,                // Register-register ALU
        OP_BRANCH = 7'b1100011,                // Conditional branches
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    // Branch kinds share the funct3 encoding
    typedef enum logic [2:0] {
        BJ_BEQ  = 3'b000,
        BJ_BNE  = 3'b001,
        BJ_BLT  = 3'b100,
        BJ_BGE  = 3'b101,
        BJ_BLTU = 3'b110,
        BJ_BGEU = 3'b111
    } bj_type_e;

    typedef enum logic [1:0] {
        ALU_ADD      = 2'b00,                  // Address or pc arithmetic
        ALU_BRANCH   = 2'b01,                  // Compare class
        ALU_FUNCT    = 2'b10,                  // Decoded from funct3/funct7
        ALU_PASS_IMM = 2'b11                   // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE
    } imm_fmt_e;

    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_EX  = 2'b01,
        FWD_MEM = 2'b10,
        FWD_WB  = 2'b11
    } fwd_sel_e;

    localparam logic [31:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

    // ==================================================
    // Stage bundles
    // ==================================================
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] pc_plus_4;
        logic        valid;
    } fetch_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        reg_write;
        logic        valid;
        logic [31:0] result;                   // ALU result of that stage
    } fwd_src_t;

    typedef struct packed {
        fwd_src_t    src;
        logic        mem_to_reg;               // Load in MEM
        logic [31:0] read_data;
    } mem_src_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic        reg_write;
    } wb_t;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        alu_src;                  // 1 selects immediate
        logic        mem_read;
        logic        mem_write;
        logic        mem_to_reg;
        logic        reg_write;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_plus_4;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        ctrl_t       ctrl;
        logic [31:0] branch_target;
        logic        valid;
    } id_ex_t;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        is_branch;
        logic        is_jalr;
        logic        valid;
    } id_hazard_t;

endpackage

//--- hw/id_decoder.sv
// RV32I field split, control decode and immediate generation for the IF/ID word
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
    input  logic [31:0] i_inst,                // Word held in IF/ID
    output logic [4:0]  o_rs1,
    output logic [4:0]  o_rs2,
    output logic [4:0]  o_rd,
    output logic [31:0] o_imm,                 // Sign-extended immediate
    output ctrl_t       o_ctrl,
    output bj_type_e    o_bj_type,
    output logic        o_is_branch,
    output logic        o_is_jal,
    output logic        o_is_jalr
);

    // ==================================================
    // Field extraction
    // ==================================================
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_fmt_e   fmt;                           // Immediate layout of this opcode
    logic       known;                         // Opcode is in RV32I base set

    assign opcode    = opcode_e'(i_inst[6:0]);
    assign o_rd      = i_inst[11:7];
    assign funct3    = i_inst[14:12];
    assign o_rs1     = i_inst[19:15];
    assign o_rs2     = i_inst[24:20];
    assign funct7    = i_inst[31:25];
    assign o_bj_type = bj_type_e'(funct3);     // Only meaningful for branches

    // ==================================================
    // Control decode
    // ==================================================
    always_comb begin
        o_ctrl      = '0;                      // Unknown opcode stays all zero
        fmt         = IMM_NONE;
        o_is_branch = 1'b0;
        o_is_jal    = 1'b0;
        o_is_jalr   = 1'b0;
        known       = 1'b1;
        case (opcode)
            OP_LOAD: begin
                o_ctrl.alu_src    = 1'b1;      // Base + offset
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.mem_to_reg = 1'b1;
                o_ctrl.reg_write  = 1'b1;
                fmt               = IMM_I;
            end
            OP_STORE: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.mem_write = 1'b1;
                fmt              = IMM_S;
            end
            OP_IMM: begin
                o_ctrl.alu_op    = ALU_FUNCT;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                fmt              = IMM_I;
            end
            OP_OP: begin
                o_ctrl.alu_op    = ALU_FUNCT;  // rs2 operand, no immediate
                o_ctrl.reg_write = 1'b1;
            end
            OP_BRANCH: begin
                o_ctrl.alu_op = ALU_BRANCH;
                fmt           = IMM_B;
                o_is_branch   = 1'b1;
            end
            OP_JAL: begin
                o_ctrl.reg_write = 1'b1;       // Link register gets pc+4
                fmt              = IMM_J;
                o_is_jal         = 1'b1;
            end
            OP_JALR: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                fmt              = IMM_I;
                o_is_jalr        = 1'b1;
            end
            OP_LUI: begin
                o_ctrl.alu_op    = ALU_PASS_IMM;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                fmt              = IMM_U;
            end
            OP_AUIPC: begin
                o_ctrl.alu_src   = 1'b1;       // pc + upper immediate
                o_ctrl.reg_write = 1'b1;
                fmt              = IMM_U;
            end
            default: known = 1'b0;
        endcase
        if (known) begin
            o_ctrl.funct3 = funct3;
            o_ctrl.funct7 = funct7;
        end
    end

    // ==================================================
    // Immediate generation
    // ==================================================
    always_comb begin
        case (fmt)
            IMM_I:   o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
            IMM_S:   o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            IMM_B:   o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                              i_inst[30:25], i_inst[11:8], 1'b0};
            IMM_U:   o_imm = {i_inst[31:12], 12'b0};
            IMM_J:   o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                              i_inst[20], i_inst[30:21], 1'b0};
            default: o_imm = 32'b0;            // R-type and unknown
        endcase
    end

endmodule

//--- hw/id_regfile.sv
// Integer register file with two read ports, one write port and optional bypass
`timescale 1ns/1ps

module id_regfile import id_pkg::*; #(
    parameter bit P_RF_BYPASS = 1'b1           // Write-through on same-cycle read
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [4:0]  i_rs1_addr,
    input  logic [4:0]  i_rs2_addr,
    input  wb_t         i_wb,                  // Write port from WB
    output logic [31:0] o_rs1_data,
    output logic [31:0] o_rs2_data
);

    logic [31:0] regs [1:31];                  // x0 has no storage

    // Write port drops x0 writes
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (i_wb.reg_write && (i_wb.rd != 5'd0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    function automatic logic [31:0] rd_port(input logic [4:0] addr);
        logic [31:0] data;
        data = 32'b0;                          // x0 reads zero
        if (addr != 5'd0) begin
            if (P_RF_BYPASS && i_wb.reg_write && (i_wb.rd == addr)) begin
                data = i_wb.data;              // Same-cycle write wins
            end else begin
                data = regs[addr];
            end
        end
        return data;
    endfunction

    always_comb begin
        o_rs1_data = rd_port(i_rs1_addr);
        o_rs2_data = rd_port(i_rs2_addr);
    end

endmodule

//--- hw/id_branch_unit.sv
// Branch operand forwarding, compare and next-PC selection for ID-stage resolution
`timescale 1ns/1ps

module id_branch_unit import id_pkg::*; (
    input  logic [31:0] i_pc,                  // IF/ID pc
    input  logic [4:0]  i_rs1,
    input  logic [4:0]  i_rs2,
    input  logic [31:0] i_rs1_data,            // Register file reads
    input  logic [31:0] i_rs2_data,
    input  logic [31:0] i_imm,
    input  bj_type_e    i_bj_type,
    input  logic        i_is_branch,
    input  logic        i_is_jal,
    input  logic        i_is_jalr,
    input  logic        i_stall_if_id,
    input  fwd_src_t    i_ex,
    input  mem_src_t    i_mem,
    input  wb_t         i_wb,
    output logic [31:0] o_next_pc,
    output logic [31:0] o_jalr_target,
    output logic        o_flush_if_id          // Redirect fetch
);

    // ==================================================
    // Forwarding
    // ==================================================
    fwd_sel_e    sel_a;                        // rs1 source
    fwd_sel_e    sel_b;                        // rs2 source
    logic [31:0] mem_fwd_data;
    logic [31:0] rs1_fwd;
    logic [31:0] rs2_fwd;

    // Youngest producer wins and x0 is never forwarded
    function automatic fwd_sel_e fwd_pick(input logic [4:0] rs, input fwd_src_t ex,
                                          input mem_src_t mem, input wb_t wb);
        fwd_sel_e sel;
        sel = FWD_RF;
        if (rs != 5'd0) begin
            if (ex.reg_write && ex.valid && (ex.rd == rs)) begin
                sel = FWD_EX;
            end else if (mem.src.reg_write && mem.src.valid && (mem.src.rd == rs)) begin
                sel = FWD_MEM;
            end else if (wb.reg_write && (wb.rd == rs)) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] rf,
                                            input logic [31:0] ex, input logic [31:0] mem,
                                            input logic [31:0] wb);
        logic [31:0] data;
        case (sel)
            FWD_EX:  data = ex;
            FWD_MEM: data = mem;
            FWD_WB:  data = wb;
            default: data = rf;
        endcase
        return data;
    endfunction

    assign sel_a        = fwd_pick(i_rs1, i_ex, i_mem, i_wb);
    assign sel_b        = fwd_pick(i_rs2, i_ex, i_mem, i_wb);
    assign mem_fwd_data = i_mem.mem_to_reg ? i_mem.read_data : i_mem.src.result; // Load data
    assign rs1_fwd      = fwd_mux(sel_a, i_rs1_data, i_ex.result, mem_fwd_data, i_wb.data);
    assign rs2_fwd      = fwd_mux(sel_b, i_rs2_data, i_ex.result, mem_fwd_data, i_wb.data);

    // ==================================================
    // Compare and redirect
    // ==================================================
    logic        eq;
    logic        lt_s;
    logic        lt_u;
    logic        cond;                         // Condition for this bj_type
    logic        taken;
    logic [31:0] pc_rel_target;                // Branch and jal target

    assign eq   = (rs1_fwd == rs2_fwd);
    assign lt_s = ($signed(rs1_fwd) < $signed(rs2_fwd));
    assign lt_u = (rs1_fwd < rs2_fwd);

    always_comb begin
        case (i_bj_type)
            BJ_BEQ:  cond = eq;
            BJ_BNE:  cond = ~eq;
            BJ_BLT:  cond = lt_s;
            BJ_BGE:  cond = ~lt_s;
            BJ_BLTU: cond = lt_u;
            BJ_BGEU: cond = ~lt_u;
            default: cond = 1'b0;              // funct3 010/011 never branch
        endcase
    end

    assign taken         = i_is_branch & cond;
    assign pc_rel_target = i_pc + i_imm;
    assign o_jalr_target = (rs1_fwd + i_imm) & ~32'd1; // Bit 0 cleared for jalr

    assign o_next_pc = i_is_jalr              ? o_jalr_target :
                       (i_is_jal | taken)     ? pc_rel_target :
                                                i_pc + 32'd4;

    assign o_flush_if_id = ~i_stall_if_id & (i_is_jal | i_is_jalr | taken);

endmodule

//--- hw/id_stage.sv
// RV32I decode stage with IF/ID and ID/EX registers and in-stage branch resolution
`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
    parameter bit P_RF_BYPASS = 1'b1           // Register file write-through
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  fetch_t      i_fetch,               // From IF
    input  logic        i_stall_if_id,
    input  logic        i_flush_if_id,
    input  logic        i_rst_stall,           // Bubble into ID/EX
    input  logic        i_stall_id_ex,         // Hold ID/EX
    input  wb_t         i_wb,
    input  fwd_src_t    i_ex,
    input  mem_src_t    i_mem,
    output logic [31:0] o_next_pc,
    output logic        o_flush_if_id,
    output id_hazard_t  o_hazard,
    output id_ex_t      o_id_ex
);

    // ==================================================
    // IF/ID register
    // ==================================================
    fetch_t if_id;
    logic   flush_d;                           // Flush seen one edge ago

    // Synchronous imem returns one more wrong-path word, so squash twice
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flush_d <= 1'b0;
        end else begin
            flush_d <= i_flush_if_id;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            if_id <= '0;
        end else if (i_flush_if_id || flush_d) begin
            if_id.inst      <= NOP_INST;
            if_id.pc        <= 32'b0;
            if_id.pc_plus_4 <= 32'b0;
            if_id.valid     <= 1'b0;
        end else if (i_stall_if_id) begin
            if_id.valid <= 1'b0;               // Fields hold
        end else begin
            if_id <= i_fetch;
        end
    end

    // ==================================================
    // Decode, register read, branch resolution
    // ==================================================
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    ctrl_t       ctrl;
    bj_type_e    bj_type;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic [31:0] rs1_data;                     // Unforwarded reads
    logic [31:0] rs2_data;
    logic [31:0] jalr_target;

    id_decoder u_decoder (
        .i_inst      (if_id.inst),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_rd        (rd),
        .o_imm       (imm),
        .o_ctrl      (ctrl),
        .o_bj_type   (bj_type),
        .o_is_branch (is_branch),
        .o_is_jal    (is_jal),
        .o_is_jalr   (is_jalr)
    );

    id_regfile #(
        .P_RF_BYPASS (P_RF_BYPASS)
    ) u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1),
        .i_rs2_addr (rs2),
        .i_wb       (i_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    id_branch_unit u_branch (
        .i_pc          (if_id.pc),
        .i_rs1         (rs1),
        .i_rs2         (rs2),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .i_imm         (imm),
        .i_bj_type     (bj_type),
        .i_is_branch   (is_branch),
        .i_is_jal      (is_jal),
        .i_is_jalr     (is_jalr),
        .i_stall_if_id (i_stall_if_id),
        .i_ex          (i_ex),
        .i_mem         (i_mem),
        .i_wb          (i_wb),
        .o_next_pc     (o_next_pc),
        .o_jalr_target (jalr_target),
        .o_flush_if_id (o_flush_if_id)
    );

    // Hazard unit view of IF/ID
    always_comb begin
        o_hazard.rs1       = rs1;
        o_hazard.rs2       = rs2;
        o_hazard.is_branch = is_branch;
        o_hazard.is_jalr   = is_jalr;
        o_hazard.valid     = if_id.valid;
    end

    // ==================================================
    // ID/EX register
    // ==================================================
    id_ex_t id_ex_next;

    always_comb begin
        id_ex_next.pc            = if_id.pc;
        id_ex_next.pc_plus_4     = if_id.pc_plus_4;
        id_ex_next.rs1_data      = rs1_data;
        id_ex_next.rs2_data      = rs2_data;
        id_ex_next.imm           = imm;
        id_ex_next.rs1           = rs1;
        id_ex_next.rs2           = rs2;
        id_ex_next.rd            = rd;
        id_ex_next.ctrl          = ctrl;
        id_ex_next.branch_target = is_jalr ? jalr_target : if_id.pc + imm;
        id_ex_next.valid         = if_id.valid;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else if (i_stall_id_ex) begin
            o_id_ex <= o_id_ex;                // Downstream stall
        end else if (i_rst_stall) begin
            o_id_ex           <= '0;           // Load-use bubble
            o_id_ex.pc        <= if_id.pc;
            o_id_ex.pc_plus_4 <= if_id.pc_plus_4;
        end else if (if_id.valid) begin
            o_id_ex <= id_ex_next;
        end else begin
            o_id_ex.valid <= 1'b0;             // Payload holds
        end
    end

endmodule

//--- testbench/id_checker.sv
// Decode stage reference model that compares DUT outputs at every falling edge
`timescale 1ns/1ps

module id_checker import id_pkg::*; #(
    parameter bit P_RF_BYPASS = 1'b1           // Must match the DUT setting
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  fetch_t      i_fetch,
    input  logic        i_stall_if_id,
    input  logic        i_flush_if_id,
    input  logic        i_rst_stall,
    input  logic        i_stall_id_ex,
    input  wb_t         i_wb,
    input  fwd_src_t    i_ex,
    input  mem_src_t    i_mem,
    input  logic [31:0] i_dut_next_pc,         // Observed DUT outputs
    input  logic        i_dut_flush,
    input  id_hazard_t  i_dut_hazard,
    input  id_ex_t      i_dut_id_ex,
    output int          o_checks,
    output int          o_errors
);

    typedef struct packed {
        logic [31:0] imm;
        ctrl_t       ctrl;
        logic        br;
        logic        jal;
        logic        jalr;
    } dec_t;

    fetch_t      m_if;                         // Model IF/ID
    logic        m_flush_d;
    logic [31:0] m_regs [32];
    id_ex_t      m_id_ex;                      // Model ID/EX
    logic        primed = 1'b0;                // Model state known after first reset
    int          checks = 0;
    int          errors = 0;

    assign o_checks = checks;
    assign o_errors = errors;

    // ==================================================
    // Model decode
    // ==================================================
    function automatic ctrl_t mk_ctrl(input alu_op_e op, input logic [4:0] f,
                                      input logic [31:0] w);
        ctrl_t c;
        c = {op, f, w[14:12], w[31:25]};       // f is src, rd, wr, m2r, we
        return c;
    endfunction

    function automatic dec_t decode(input logic [31:0] w);
        dec_t        d;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        d = '0;
        case (w[6:0])
            OP_LOAD: begin
                d.ctrl = mk_ctrl(ALU_ADD, 5'b11011, w);
                d.imm  = imm_i;
            end
            OP_STORE: begin
                d.ctrl = mk_ctrl(ALU_ADD, 5'b10100, w);
                d.imm  = imm_s;
            end
            OP_IMM: begin
                d.ctrl = mk_ctrl(ALU_FUNCT, 5'b10001, w);
                d.imm  = imm_i;
            end
            OP_OP:     d.ctrl = mk_ctrl(ALU_FUNCT, 5'b00001, w);
            OP_BRANCH: begin
                d.ctrl = mk_ctrl(ALU_BRANCH, 5'b00000, w);
                d.imm  = imm_b;
                d.br   = 1'b1;
            end
            OP_JAL: begin
                d.ctrl = mk_ctrl(ALU_ADD, 5'b00001, w);
                d.imm  = imm_j;
                d.jal  = 1'b1;
            end
            OP_JALR: begin
                d.ctrl = mk_ctrl(ALU_ADD, 5'b10001, w);
                d.imm  = imm_i;
                d.jalr = 1'b1;
            end
            OP_LUI: begin
                d.ctrl = mk_ctrl(ALU_PASS_IMM, 5'b10001, w);
                d.imm  = imm_u;
            end
            OP_AUIPC: begin
                d.ctrl = mk_ctrl(ALU_ADD, 5'b10001, w);
                d.imm  = imm_u;
            end
            default:   d = '0;                 // Unknown opcode
        endcase
        return d;
    endfunction

    // ==================================================
    // Model register read, forwarding, compare
    // ==================================================
    function automatic logic [31:0] rf_read(input logic [4:0] addr);
        if (addr == 5'd0) return 32'd0;
        if (P_RF_BYPASS && i_wb.reg_write && i_wb.rd == addr) return i_wb.data;
        return m_regs[addr];
    endfunction

    function automatic logic [31:0] fwd(input logic [4:0] rs, input logic [31:0] rf);
        if (rs == 5'd0) return rf;
        if (i_ex.reg_write && i_ex.valid && i_ex.rd == rs) return i_ex.result;
        if (i_mem.src.reg_write && i_mem.src.valid && i_mem.src.rd == rs) begin
            return i_mem.mem_to_reg ? i_mem.read_data : i_mem.src.result;
        end
        if (i_wb.reg_write && i_wb.rd == rs) return i_wb.data;
        return rf;
    endfunction

    function automatic logic br_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [255:0] exp,
                             input logic [255:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected %0h got %0h at %0t", name, exp, act, $time);
        end
    endtask

    // ==================================================
    // Compare, then advance the model
    // ==================================================
    always @(negedge i_clk) begin
        logic [31:0] w;
        dec_t        d;
        logic [31:0] a_rf;
        logic [31:0] b_rf;
        logic [31:0] a;
        logic [31:0] b;
        logic        taken;
        logic [31:0] jalr_t;
        logic [31:0] rel_t;
        logic [31:0] exp_pc;
        id_hazard_t  hz;
        id_ex_t      nx;
        w      = m_if.inst;
        d      = decode(w);
        a_rf   = rf_read(w[19:15]);
        b_rf   = rf_read(w[24:20]);
        a      = fwd(w[19:15], a_rf);
        b      = fwd(w[24:20], b_rf);
        taken  = d.br && br_cond(w[14:12], a, b);
        jalr_t = (a + d.imm) & ~32'd1;
        rel_t  = m_if.pc + d.imm;
        exp_pc = d.jalr ? jalr_t : ((d.jal || taken) ? rel_t : m_if.pc + 32'd4);
        hz     = {w[19:15], w[24:20], d.br, d.jalr, m_if.valid};
        if (primed) begin
            check_val("o_next_pc", 256'(exp_pc), 256'(i_dut_next_pc));
            check_val("o_flush_if_id", 256'(!i_stall_if_id && (d.jal || d.jalr || taken)),
                      256'(i_dut_flush));
            check_val("o_hazard", 256'(hz), 256'(i_dut_hazard));
            check_val("o_id_ex", 256'(m_id_ex), 256'(i_dut_id_ex));
        end
        nx.pc            = m_if.pc;
        nx.pc_plus_4     = m_if.pc_plus_4;
        nx.rs1_data      = a_rf;               // Unforwarded reads go to EX
        nx.rs2_data      = b_rf;
        nx.imm           = d.imm;
        nx.rs1           = w[19:15];
        nx.rs2           = w[24:20];
        nx.rd            = w[11:7];
        nx.ctrl          = d.ctrl;
        nx.branch_target = d.jalr ? jalr_t : rel_t;
        nx.valid         = 1'b1;
        if (i_rst) begin
            m_if      = '0;
            m_flush_d = 1'b0;
            m_id_ex   = '0;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = 32'd0;
            end
            primed    = 1'b1;
        end else begin
            if (!i_stall_id_ex) begin
                if (i_rst_stall) begin
                    m_id_ex           = '0;    // Bubble keeps only the pcs
                    m_id_ex.pc        = m_if.pc;
                    m_id_ex.pc_plus_4 = m_if.pc_plus_4;
                end else if (m_if.valid) begin
                    m_id_ex = nx;
                end else begin
                    m_id_ex.valid = 1'b0;
                end
            end
            if (i_flush_if_id || m_flush_d) begin
                m_if      = '0;                // Squashed slot
                m_if.inst = NOP_INST;
            end else if (i_stall_if_id) begin
                m_if.valid = 1'b0;
            end else begin
                m_if = i_fetch;
            end
            m_flush_d = i_flush_if_id;
            if (i_wb.reg_write && i_wb.rd != 5'd0) begin
                m_regs[i_wb.rd] = i_wb.data;
            end
        end
    end

endmodule

//--- testbench/tb_id_stage.sv
// Decode stage testbench with seeded random instructions, forwarding traffic and stalls
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst;
    fetch_t      fetch;
    logic        stall_if_id;
    logic        flush_if_id;
    logic        rst_stall;
    logic        stall_id_ex;
    wb_t         wb;
    fwd_src_t    ex;
    mem_src_t    mem;
    logic [31:0] next_pc;
    logic        flush_req;
    id_hazard_t  hazard;
    id_ex_t      id_ex;
    int          checks;
    int          errors;
    int          timeouts;                     // Waits that gave up
    int          seed;
    logic [31:0] fetch_pc;                     // Sequential fetch address

    always #50 clk = ~clk;                     // 100 ns period

    id_stage #(.P_RF_BYPASS(1'b1)) dut0 (
        .i_clk(clk), .i_rst(rst), .i_fetch(fetch),
        .i_stall_if_id(stall_if_id), .i_flush_if_id(flush_if_id),
        .i_rst_stall(rst_stall), .i_stall_id_ex(stall_id_ex),
        .i_wb(wb), .i_ex(ex), .i_mem(mem),
        .o_next_pc(next_pc), .o_flush_if_id(flush_req),
        .o_hazard(hazard), .o_id_ex(id_ex)
    );

    id_checker #(.P_RF_BYPASS(1'b1)) chk0 (
        .i_clk(clk), .i_rst(rst), .i_fetch(fetch),
        .i_stall_if_id(stall_if_id), .i_flush_if_id(flush_if_id),
        .i_rst_stall(rst_stall), .i_stall_id_ex(stall_id_ex),
        .i_wb(wb), .i_ex(ex), .i_mem(mem),
        .i_dut_next_pc(next_pc), .i_dut_flush(flush_req),
        .i_dut_hazard(hazard), .i_dut_id_ex(id_ex),
        .o_checks(checks), .o_errors(errors)
    );

    // ==================================================
    // Random sources
    // ==================================================
    function automatic int unsigned urand(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Mostly x0..x3 so forwarding and bypass hit often
    function automatic logic [4:0] pick_reg();
        return (urand(4) != 0) ? 5'(urand(4)) : 5'(urand(32));
    endfunction

    function automatic logic [31:0] rand_data();
        return (urand(4) == 0) ? 32'(urand(4)) : 32'($random(seed)); // Small values tie
    endfunction

    function automatic logic [31:0] rand_inst(input int unsigned br_pct);
        logic [31:0] w;
        logic [2:0]  f3;
        int unsigned k;
        w = $random(seed);
        k = (urand(100) < br_pct) ? 4 + urand(3) : urand(9);
        case (k)
            0:       w[6:0] = OP_LOAD;
            1:       w[6:0] = OP_STORE;
            2:       w[6:0] = OP_IMM;
            3:       w[6:0] = OP_OP;
            4:       w[6:0] = OP_BRANCH;
            5:       w[6:0] = OP_JAL;
            6:       w[6:0] = OP_JALR;
            7:       w[6:0] = OP_LUI;
            default: w[6:0] = OP_AUIPC;
        endcase
        if (urand(2) == 0) begin
            w[19:15] = 5'(urand(4));
            w[24:20] = 5'(urand(4));
        end
        f3 = 3'(urand(6));
        if (f3 >= 3'd2) f3 = f3 + 3'd2;        // Legal kinds 0,1,4..7
        if (k == 4) w[14:12] = f3;
        if (k == 6) w[14:12] = 3'b000;
        return w;
    endfunction

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic drive_cycle(input int unsigned br_pct, sif_pct, fl_pct, rs_pct, sex_pct);
        fetch_t   f;
        wb_t      w;
        fwd_src_t e;
        mem_src_t m;
        f.inst          = rand_inst(br_pct);
        f.pc            = fetch_pc;
        f.pc_plus_4     = fetch_pc + 32'd4;
        f.valid         = urand(8) != 0;
        fetch_pc        = fetch_pc + 32'd4;
        w.rd            = pick_reg();
        w.data          = rand_data();
        w.reg_write     = urand(4) != 0;
        e.rd            = pick_reg();
        e.reg_write     = urand(4) != 0;
        e.valid         = urand(4) != 0;
        e.result        = rand_data();
        m.src.rd        = pick_reg();
        m.src.reg_write = urand(4) != 0;
        m.src.valid     = urand(4) != 0;
        m.src.result    = rand_data();
        m.mem_to_reg    = urand(2) == 0;
        m.read_data     = rand_data();
        @(posedge clk);
        fetch       <= f;
        wb          <= w;
        ex          <= e;
        mem         <= m;
        stall_if_id <= urand(100) < sif_pct;
        flush_if_id <= urand(100) < fl_pct;
        rst_stall   <= urand(100) < rs_pct;
        stall_id_ex <= urand(100) < sex_pct;
    endtask

    task automatic run_test(input string name, input int cycles,
                            input int unsigned br_pct, sif_pct, fl_pct, rs_pct, sex_pct);
        for (int i = 0; i < cycles; i++) begin
            drive_cycle(br_pct, sif_pct, fl_pct, rs_pct, sex_pct);
        end
        $display("Test %s finished after %0d cycles, mismatches so far %0d", name, cycles, errors);
    endtask

    // Clean cycles until ID/EX holds a valid instruction again
    task automatic wait_id_ex_valid(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!id_ex.valid && n < 20) begin
            drive_cycle(0, 0, 0, 0, 0);
            @(negedge clk);
            n++;
        end
        if (!id_ex.valid) begin
            timeouts++;
            $display("Timeout during %s: o_id_ex never became valid in 20 cycles", what);
        end
    endtask

    initial begin
        seed        = 32'h2a7;
        fetch_pc    = 32'h0000_1000;
        timeouts    = 0;
        rst         <= 1'b1;
        fetch       <= '0;
        stall_if_id <= 1'b0;
        flush_if_id <= 1'b0;
        rst_stall   <= 1'b0;
        stall_id_ex <= 1'b0;
        wb          <= '0;
        ex          <= '0;
        mem         <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        run_test("reset", 3, 0, 0, 0, 0, 0);
        wait_id_ex_valid("decode start");
        run_test("decode", 200, 10, 0, 0, 0, 0);
        run_test("branch", 300, 70, 0, 0, 0, 0);
        for (int i = 0; i < 8; i++) begin
            drive_cycle(20, 0, 100, 0, 0);     // One-cycle flush pulse
            drive_cycle(20, 0, 0, 0, 0);
            drive_cycle(20, 0, 0, 0, 0);
            wait_id_ex_valid("flush recovery");
        end
        $display("Test flush finished, mismatches so far %0d", errors);
        run_test("stall", 300, 40, 20, 5, 15, 15);
        repeat (2) drive_cycle(0, 0, 0, 0, 0);
        @(negedge clk);
        #10;
        $display("Summary: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_branch_unit.sv
hw/id_stage.sv
testbench/id_checker.sv
testbench/tb_id_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f vlog.f --top-module tb_id_stage -Mdir obj_dir
./obj_dir/Vtb_id_stage | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
